// File: hw/tx_defines.svh
// tx bit interface widths, depths, queue count and start pulse length
`ifndef TX_DEFINES_SVH
`define TX_DEFINES_SVH

// stream and frame buffer word width
`define TX_DATA_W 64
// frame buffer address width
`define TX_BUF_AW 10
// word count field of a descriptor
`define TX_LEN_W 13

// descriptor queues
`define TX_NUM_Q 4
`define TX_QIDX_W 2
`define TX_DESC_DEPTH 64
// occupancy count, one bit wider than the pointers
`define TX_CNT_W 7

// mac sequence number
`define TX_SN_W 10
// start pulse stretch, in clk cycles
`define TX_START_LEN 6
// auto-start threshold address
`define TX_TH_W 10

`endif

// File: hw/tx_pkg.sv
// tx bit interface shared types: descriptor, buffer write request, controller states
`include "tx_defines.svh"

package tx_pkg;

    // host descriptor, one per frame
    // prio and sn come from the linux stack
    typedef struct packed {
        logic [1:0]              prio;
        logic [`TX_SN_W-1:0]     sn;
        // reserved
        logic [1:0]              spare;
        logic [3:0]              retrans_limit;
        logic                    need_ack;
        // frame length in stream words
        logic [`TX_LEN_W-1:0]    len;
    } tx_desc_t;

    // one write into port a of the frame buffer
    typedef struct packed {
        logic                    en;
        logic [`TX_BUF_AW-1:0]   addr;
        logic [`TX_DATA_W-1:0]   data;
    } buf_wr_t;

    // frame loader states
    typedef enum logic [1:0] {
        // idle, looking for an eligible queue
        wait_chance = 2'd0,
        // descriptor pop in flight
        fetch       = 2'd1,
        // pulling stream words into the buffer
        load        = 2'd2,
        // frame in the buffer, waiting for the phy
        wait_end    = 2'd3
    } ctl_state_t;

endpackage

// File: hw/desc_fifo.sv
// desc_fifo: single-clock show-ahead descriptor FIFO with occupancy count
`include "tx_defines.svh"

module desc_fifo (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  push,
    input  tx_pkg::tx_desc_t      din,
    input  logic                  pop,
    output tx_pkg::tx_desc_t      dout,
    output logic                  empty,
    output logic [`TX_CNT_W-1:0]  count
);

    localparam int PTR_W = $clog2(`TX_DESC_DEPTH);

    tx_pkg::tx_desc_t mem [`TX_DESC_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign empty = (count == '0);
    assign full  = (count == `TX_CNT_W'(`TX_DESC_DEPTH));

    // overflow and underflow requests are dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // head is always visible
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: hw/desc_queue_bank.sv
// desc_queue_bank: four priority descriptor queues fed on the falling edge of dma done
`include "tx_defines.svh"

module desc_queue_bank (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    dma_done,
    input  logic [`TX_QIDX_W-1:0]   queue_sel,
    input  tx_pkg::tx_desc_t        desc_in,
    input  logic [`TX_NUM_Q-1:0]    pop,
    output tx_pkg::tx_desc_t        head [`TX_NUM_Q],
    output logic [`TX_NUM_Q-1:0]    empty,
    output logic [`TX_CNT_W-1:0]    data_count [`TX_NUM_Q]
);

    logic                 dma_done_d;
    logic                 dma_fall;
    logic [`TX_NUM_Q-1:0] push;

    // dma finished once the flag drops
    assign dma_fall = dma_done_d & ~dma_done;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dma_done_d <= 1'b0;
            push       <= '0;
        end else begin
            dma_done_d <= dma_done;
            // one-hot push into the queue the host named
            push <= '0;
            if (dma_fall) begin
                push[queue_sel] <= 1'b1;
            end
        end
    end

    // host keeps desc_in stable until the push lands
    for (genvar q = 0; q < `TX_NUM_Q; q++) begin : g_q
        desc_fifo fifo_i (
            .clk   (clk),
            .rstn  (rstn),
            .push  (push[q]),
            .din   (desc_in),
            .pop   (pop[q]),
            .dout  (head[q]),
            .empty (empty[q]),
            .count (data_count[q])
        );
    end

endmodule

// File: hw/tx_ctrl.sv
// tx_ctrl: strict-priority queue scheduler and frame loader into the tx buffer
`include "tx_defines.svh"

module tx_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  tx_pkg::tx_desc_t        head [`TX_NUM_Q],
    input  logic [`TX_NUM_Q-1:0]    empty,
    input  logic [`TX_NUM_Q-1:0]    high_tx_allowed,
    input  logic                    tx_bb_is_ongoing,
    input  logic                    xpu_owns,
    input  logic                    tx_end,
    input  logic                    tx_try_complete,
    input  logic [`TX_DATA_W-1:0]   s_axis_data,
    input  logic                    s_axis_emptyn,
    output logic [`TX_NUM_Q-1:0]    pop,
    output logic                    ask,
    output tx_pkg::buf_wr_t         loader_wr,
    output logic [`TX_QIDX_W-1:0]   tx_queue_idx,
    output logic                    tx_pkt_need_ack,
    output logic [3:0]              tx_pkt_retrans_limit,
    output logic [`TX_SN_W-1:0]     tx_pkt_sn,
    output logic [1:0]              linux_prio
);

    localparam int unsigned QW = `TX_QIDX_W;

    tx_pkg::ctl_state_t   state;
    tx_pkg::tx_desc_t     cur_desc;
    tx_pkg::tx_desc_t     head_sel;
    logic [`TX_LEN_W-1:0] wr_cnt;
    logic                 accept;
    logic                 pick_valid;
    logic [QW-1:0]        pick_idx;

    // lowest allowed non-empty queue wins
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int q = `TX_NUM_Q - 1; q >= 0; q--) begin
            if (high_tx_allowed[q] && !empty[q]) begin
                pick_valid = 1'b1;
                pick_idx   = QW'(q);
            end
        end
    end

    assign head_sel = head[tx_queue_idx];
    assign accept   = ask & s_axis_emptyn;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= tx_pkg::wait_chance;
            pop          <= '0;
            ask          <= 1'b0;
            wr_cnt       <= '0;
            tx_queue_idx <= '0;
            cur_desc     <= '0;
        end else begin
            pop <= '0;
            case (state)
                tx_pkg::wait_chance: begin
                    wr_cnt <= '0;
                    // hold off while the phy or the xpu is busy
                    if (pick_valid && !tx_bb_is_ongoing && !xpu_owns) begin
                        pop[pick_idx] <= 1'b1;
                        tx_queue_idx  <= pick_idx;
                        state         <= tx_pkg::fetch;
                    end
                end
                tx_pkg::fetch: begin
                    // head still valid, pop retires it at this edge
                    cur_desc <= head_sel;
                    if (head_sel.len != '0) begin
                        ask   <= 1'b1;
                        state <= tx_pkg::load;
                    end else begin
                        state <= tx_pkg::wait_end;
                    end
                end
                tx_pkg::load: begin
                    if (accept) begin
                        wr_cnt <= wr_cnt + 1'b1;
                        // last word taken
                        if (wr_cnt == cur_desc.len - 1'b1) begin
                            ask   <= 1'b0;
                            state <= tx_pkg::wait_end;
                        end
                    end
                end
                tx_pkg::wait_end: begin
                    if (tx_end) begin
                        state <= tx_pkg::wait_chance;
                    end
                end
                default: begin
                    state <= tx_pkg::wait_chance;
                end
            endcase
        end
    end

    // buffer write, one cycle behind the stream handshake
    always_ff @(posedge clk) begin
        if (!rstn) begin
            loader_wr.en <= 1'b0;
        end else begin
            loader_wr.en <= accept;
        end
    end

    always_ff @(posedge clk) begin
        loader_wr.addr <= wr_cnt[`TX_BUF_AW-1:0];
        loader_wr.data <= s_axis_data;
    end

    // snapshot for the mac once a try is over
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_pkt_sn  <= '0;
            linux_prio <= '0;
        end else if (tx_try_complete) begin
            tx_pkt_sn  <= cur_desc.sn;
            linux_prio <= cur_desc.prio;
        end
    end

    assign tx_pkt_need_ack      = cur_desc.need_ack;
    assign tx_pkt_retrans_limit = cur_desc.retrans_limit;

endmodule

// File: hw/buf_write_port.sv
// buf_write_port: port a arbitration between loader and xpu, with auto-start pulse
`include "tx_defines.svh"

module buf_write_port (
    input  logic                  clk,
    input  logic                  rstn,
    input  tx_pkg::buf_wr_t       loader_wr,
    input  tx_pkg::buf_wr_t       xpu_wr,
    input  logic                  ack_tx_flag,
    input  logic                  retrans_in_progress,
    input  logic                  auto_start_mode,
    input  logic [`TX_TH_W-1:0]   num_dma_symbol_th,
    output tx_pkg::buf_wr_t       ram_wr,
    output logic                  xpu_owns,
    output logic                  start
);

    logic                     th_match;
    logic [`TX_START_LEN-1:0] start_sr;

    // xpu holds the port for the whole ack or retransmission
    assign xpu_owns = ack_tx_flag | retrans_in_progress;
    assign ram_wr   = xpu_owns ? xpu_wr : loader_wr;

    // only a real write to the threshold address counts
    assign th_match = ram_wr.en && (ram_wr.addr == num_dma_symbol_th);

    // shift the match along to stretch it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            start_sr <= '0;
        end else begin
            start_sr <= {start_sr[`TX_START_LEN-2:0], th_match};
        end
    end

    // auto-start off means the mac starts the phy itself
    assign start = auto_start_mode & (|start_sr);

endmodule

// File: hw/tx_buffer.sv
// tx_buffer: dual-port frame RAM, write-first port a, read-only port b
`include "tx_defines.svh"

module tx_buffer (
    input  logic                  clk,
    input  tx_pkg::buf_wr_t       ram_wr,
    input  logic [`TX_BUF_AW-1:0] rd_addr_b,
    output logic [`TX_DATA_W-1:0] douta,
    output logic [`TX_DATA_W-1:0] doutb
);

    logic [`TX_DATA_W-1:0] mem [2**`TX_BUF_AW];

    // port a, new data shows on douta during a write
    always_ff @(posedge clk) begin
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= ram_wr.data;
            douta            <= ram_wr.data;
        end else begin
            douta <= mem[ram_wr.addr];
        end
    end

    // port b feeds the phy
    always_ff @(posedge clk) begin
        doutb <= mem[rd_addr_b];
    end

endmodule

// File: hw/tx_bit_intf.sv
// tx_bit_intf: tx bit interface top, descriptor queues, loader and frame buffer
`include "tx_defines.svh"

module tx_bit_intf (
    input  logic                   clk,
    input  logic                   rstn,
    // host descriptor path
    input  logic                   dma_done,
    input  logic [`TX_QIDX_W-1:0]  queue_sel,
    input  tx_pkg::tx_desc_t       desc_in,
    output logic [`TX_CNT_W-1:0]   data_count [`TX_NUM_Q],
    // stream source
    input  logic [`TX_DATA_W-1:0]  s_axis_data,
    input  logic                   s_axis_emptyn,
    output logic                   ask,
    // low-level mac
    input  logic [`TX_NUM_Q-1:0]   high_tx_allowed,
    input  logic                   tx_bb_is_ongoing,
    input  logic                   tx_try_complete,
    input  logic                   ack_tx_flag,
    input  logic                   retrans_in_progress,
    input  tx_pkg::buf_wr_t        xpu_wr,
    output logic [`TX_DATA_W-1:0]  douta,
    output logic [`TX_QIDX_W-1:0]  tx_queue_idx,
    output logic                   tx_pkt_need_ack,
    output logic [3:0]             tx_pkt_retrans_limit,
    output logic [`TX_SN_W-1:0]    tx_pkt_sn,
    output logic [1:0]             linux_prio,
    // phy side
    input  logic                   auto_start_mode,
    input  logic [`TX_TH_W-1:0]    num_dma_symbol_th,
    input  logic                   tx_end,
    input  logic [`TX_BUF_AW-1:0]  bram_addr,
    output logic [`TX_DATA_W-1:0]  bram_data,
    output logic                   start
);

    tx_pkg::tx_desc_t     head [`TX_NUM_Q];
    logic [`TX_NUM_Q-1:0] empty;
    logic [`TX_NUM_Q-1:0] pop;
    tx_pkg::buf_wr_t      loader_wr;
    tx_pkg::buf_wr_t      ram_wr;
    logic                 xpu_owns;

    desc_queue_bank bank_i (
        .clk        (clk),
        .rstn       (rstn),
        .dma_done   (dma_done),
        .queue_sel  (queue_sel),
        .desc_in    (desc_in),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .data_count (data_count)
    );

    tx_ctrl ctrl_i (
        .clk                  (clk),
        .rstn                 (rstn),
        .head                 (head),
        .empty                (empty),
        .high_tx_allowed      (high_tx_allowed),
        .tx_bb_is_ongoing     (tx_bb_is_ongoing),
        .xpu_owns             (xpu_owns),
        .tx_end               (tx_end),
        .tx_try_complete      (tx_try_complete),
        .s_axis_data          (s_axis_data),
        .s_axis_emptyn        (s_axis_emptyn),
        .pop                  (pop),
        .ask                  (ask),
        .loader_wr            (loader_wr),
        .tx_queue_idx         (tx_queue_idx),
        .tx_pkt_need_ack      (tx_pkt_need_ack),
        .tx_pkt_retrans_limit (tx_pkt_retrans_limit),
        .tx_pkt_sn            (tx_pkt_sn),
        .linux_prio           (linux_prio)
    );

    // loader and xpu share port a
    buf_write_port wr_port_i (
        .clk                 (clk),
        .rstn                (rstn),
        .loader_wr           (loader_wr),
        .xpu_wr              (xpu_wr),
        .ack_tx_flag         (ack_tx_flag),
        .retrans_in_progress (retrans_in_progress),
        .auto_start_mode     (auto_start_mode),
        .num_dma_symbol_th   (num_dma_symbol_th),
        .ram_wr              (ram_wr),
        .xpu_owns            (xpu_owns),
        .start               (start)
    );

    tx_buffer buf_i (
        .clk       (clk),
        .ram_wr    (ram_wr),
        .rd_addr_b (bram_addr),
        .douta     (douta),
        .doutb     (bram_data)
    );

endmodule

// File: tests/tb_tx_bit_intf.sv
// testbench for the tx bit interface covering queue priority, frame loading, auto-start and xpu writes
`include "tx_defines.svh"

module tb_tx_bit_intf;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS    = 10;
    localparam int RESET_CYC = 10;
    localparam int N_TESTS   = 6;
    // worst-case length of one test in cycles
    localparam int TEST_CYC  = 300;
    localparam int WATCHDOG_NS = (RESET_CYC + N_TESTS * TEST_CYC) * CLK_NS;

    logic                  clk;
    logic                  rstn;
    logic                  dma_done;
    logic                  s_axis_emptyn;
    logic                  ask;
    logic                  start;
    logic                  tx_end;
    logic                  tx_bb_is_ongoing;
    logic                  tx_try_complete;
    logic                  ack_tx_flag;
    logic                  retrans_in_progress;
    logic                  tx_pkt_need_ack;
    logic                  auto_start_mode;
    logic [`TX_QIDX_W-1:0] queue_sel;
    logic [`TX_QIDX_W-1:0] tx_queue_idx;
    logic [`TX_NUM_Q-1:0]  high_tx_allowed;
    logic [`TX_CNT_W-1:0]  data_count [`TX_NUM_Q];
    logic [`TX_DATA_W-1:0] s_axis_data;
    logic [`TX_DATA_W-1:0] douta;
    logic [`TX_DATA_W-1:0] bram_data;
    logic [3:0]            tx_pkt_retrans_limit;
    logic [`TX_SN_W-1:0]   tx_pkt_sn;
    logic [1:0]            linux_prio;
    logic [`TX_TH_W-1:0]   num_dma_symbol_th;
    logic [`TX_BUF_AW-1:0] bram_addr;
    tx_pkg::tx_desc_t      desc_in;
    tx_pkg::buf_wr_t       xpu_wr;

    // queue model in host order per queue
    tx_pkg::tx_desc_t      qmodel [`TX_NUM_Q][$];
    // words expected in the buffer
    logic [`TX_DATA_W-1:0] sent [$];
    int errs = 0;
    int test_errs = 0;
    int checks = 0;
    int n_failed = 0;
    int cyc = 0;
    int start_cycles = 0;
    // cycle of the threshold word handshake
    int th_cyc = -100;

    tx_bit_intf dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        #(WATCHDOG_NS * 1ns);
        $display("watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errs++;
            test_errs++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string what);
        errs++;
        test_errs++;
        $display("%s", what);
    endtask

    // auto-start off keeps start low
    assert property (@(posedge clk) disable iff (!rstn) !auto_start_mode |-> !start)
        else note_failure("start went high while auto_start_mode was low");

    // start is due for TX_START_LEN cycles from one cycle after the threshold write
    always @(negedge clk) begin
        if (rstn) begin
            if (start) start_cycles++;
            check_eq("start", start,
                     auto_start_mode && cyc > th_cyc && cyc <= th_cyc + `TX_START_LEN);
        end
    end

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (test_errs == 0) ? "ok" : "FAILED", test_errs);
        if (test_errs != 0) n_failed++;
        test_errs = 0;
    endtask

    function automatic tx_pkg::tx_desc_t rand_desc(input int min_len, input int max_len);
        tx_pkg::tx_desc_t d;
        d = $urandom;
        d.spare = '0;
        d.len = `TX_LEN_W'(min_len + $urandom % (max_len - min_len + 1));
        return d;
    endfunction

    // push lands two edges after dma_done falls
    task automatic push_desc(input int q, input tx_pkg::tx_desc_t d);
        queue_sel = q;
        desc_in = d;
        dma_done = 1'b1;
        @(negedge clk);
        dma_done = 1'b0;
        @(negedge clk);
        check_eq($sformatf("data_count[%0d]", q), data_count[q], qmodel[q].size());
        @(negedge clk);
        qmodel[q].push_back(d);
        check_eq($sformatf("data_count[%0d]", q), data_count[q], qmodel[q].size());
    endtask

    // port b read with one cycle of latency
    task automatic read_back(input int base);
        int i;
        for (i = 0; i < sent.size(); i++) begin
            bram_addr = base + i;
            @(negedge clk);
            check_eq($sformatf("bram_data[%0d]", base + i), bram_data, sent[i]);
        end
    endtask

    // one frame through schedule, load under back-pressure, read back and completion
    task automatic serve_frame(input logic [`TX_NUM_Q-1:0] allow);
        tx_pkg::tx_desc_t     d;
        int                   q;
        int                   i;
        int                   k;
        q = -1;
        // strict priority picks the lowest allowed non-empty queue
        for (i = `TX_NUM_Q - 1; i >= 0; i--) begin
            if (allow[i] && qmodel[i].size() > 0) q = i;
        end
        if (q < 0) begin
            note_failure("queue model has no eligible frame");
            return;
        end
        d = qmodel[q].pop_front();
        high_tx_allowed = allow;
        k = 0;
        while (!ask && k < 50) begin
            @(negedge clk);
            k++;
        end
        if (!ask) begin
            note_failure("no frame was scheduled within 50 cycles");
            return;
        end
        check_eq("tx_queue_idx", tx_queue_idx, q);
        check_eq($sformatf("data_count[%0d]", q), data_count[q], qmodel[q].size());
        check_eq("tx_pkt_need_ack", tx_pkt_need_ack, d.need_ack);
        check_eq("tx_pkt_retrans_limit", tx_pkt_retrans_limit, d.retrans_limit);
        sent.delete();
        // stream source drops emptyn about a quarter of the time
        while (ask && k < TEST_CYC) begin
            s_axis_emptyn = ($urandom % 4) != 0;
            s_axis_data = {$urandom, $urandom};
            if (s_axis_emptyn) begin
                if (sent.size() == num_dma_symbol_th) th_cyc = cyc + 1;
                sent.push_back(s_axis_data);
            end
            @(negedge clk);
            k++;
        end
        s_axis_emptyn = 1'b0;
        if (ask) note_failure("stream load did not end");
        check_eq("accepted words", sent.size(), d.len);
        // last word is written one edge after ask falls
        @(negedge clk);
        read_back(0);
        // queues held off until the next frame
        tx_try_complete = 1'b1;
        tx_end = 1'b1;
        high_tx_allowed = '0;
        @(negedge clk);
        tx_try_complete = 1'b0;
        tx_end = 1'b0;
        check_eq("tx_pkt_sn", tx_pkt_sn, d.sn);
        check_eq("linux_prio", linux_prio, d.prio);
    endtask

    initial begin
        int i;
        void'($urandom(32'habe3648e));
        rstn = 1'b0;
        dma_done = 1'b0;
        queue_sel = '0;
        desc_in = '0;
        s_axis_data = '0;
        s_axis_emptyn = 1'b0;
        high_tx_allowed = '0;
        tx_bb_is_ongoing = 1'b0;
        tx_try_complete = 1'b0;
        ack_tx_flag = 1'b0;
        retrans_in_progress = 1'b0;
        xpu_wr = '0;
        auto_start_mode = 1'b0;
        num_dma_symbol_th = `TX_TH_W'(4);
        tx_end = 1'b0;
        bram_addr = '0;
        repeat (RESET_CYC) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        check_eq("start", start, 0);
        check_eq("ask", ask, 0);
        for (i = 0; i < `TX_NUM_Q; i++) begin
            check_eq($sformatf("data_count[%0d]", i), data_count[i], 0);
        end
        end_test(1, "reset");

        // three pushes into queue 1 and three pops
        for (i = 0; i < 3; i++) push_desc(1, rand_desc(2, 8));
        for (i = 0; i < 3; i++) serve_frame(4'b0010);
        end_test(2, "push and pop");

        push_desc(2, rand_desc(2, 6));
        push_desc(0, rand_desc(2, 6));
        push_desc(0, rand_desc(2, 6));
        serve_frame(4'b0101);
        // queue 0 still holds one but is disallowed
        serve_frame(4'b0100);
        serve_frame(4'b0001);
        end_test(3, "priority");

        push_desc(3, rand_desc(16, 24));
        serve_frame(4'b1000);
        end_test(4, "loading");

        auto_start_mode = 1'b1;
        push_desc(0, rand_desc(8, 12));
        serve_frame(4'b0001);
        check_eq("start cycles", start_cycles, `TX_START_LEN);
        auto_start_mode = 1'b0;
        push_desc(0, rand_desc(8, 12));
        serve_frame(4'b0001);
        check_eq("start cycles", start_cycles, `TX_START_LEN);
        end_test(5, "auto start");

        // while the xpu owns port a the waiting frame stays queued
        push_desc(0, rand_desc(3, 8));
        ack_tx_flag = 1'b1;
        high_tx_allowed = 4'b0001;
        sent.delete();
        for (i = 0; i < 4; i++) begin
            xpu_wr = {1'b1, `TX_BUF_AW'(700 + i), $urandom, $urandom};
            sent.push_back(xpu_wr.data);
            @(negedge clk);
            // write-first port a shows the new word
            check_eq("douta", douta, sent[i]);
        end
        xpu_wr.en = 1'b0;
        // port a reads back the xpu words
        for (i = 0; i < 4; i++) begin
            xpu_wr.addr = `TX_BUF_AW'(700 + i);
            @(negedge clk);
            check_eq("douta", douta, sent[i]);
        end
        check_eq("ask", ask, 0);
        check_eq("data_count[0]", data_count[0], 1);
        read_back(700);
        ack_tx_flag = 1'b0;
        serve_frame(4'b0001);
        end_test(6, "xpu");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 N_TESTS, n_failed, checks, errs);
        if (errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+hw
hw/tx_pkg.sv
hw/desc_fifo.sv
hw/desc_queue_bank.sv
hw/tx_ctrl.sv
hw/buf_write_port.sv
hw/tx_buffer.sv
hw/tx_bit_intf.sv
tests/tb_tx_bit_intf.sv

// File: Bender.yml
package:
  name: tx_bit_intf

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/tx_pkg.sv
      - hw/desc_fifo.sv
      - hw/desc_queue_bank.sv
      - hw/tx_ctrl.sv
      - hw/buf_write_port.sv
      - hw/tx_buffer.sv
      - hw/tx_bit_intf.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_tx_bit_intf.sv
